/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// instruction field positions
	localparam int unsigned OPCODE_W   = 7;
	localparam int unsigned FUNCT3_W   = 3;
	localparam int unsigned FUNCT7_W   = 7;
	localparam int unsigned RD_LSB     = 7;
	localparam int unsigned FUNCT3_LSB = 12;
	localparam int unsigned RS1_LSB    = 15;
	localparam int unsigned RS2_LSB    = 20;
	localparam int unsigned FUNCT7_LSB = 25;
	localparam int unsigned ALT_BIT    = 30; // picks SUB and SRA

	// accepted R-type funct7 values
	localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;

	// major opcodes kept by this core, anything else is illegal
	typedef enum logic [OPCODE_W-1:0] {
		OP_IMM = 7'b0010011, // register-immediate alu
		OP     = 7'b0110011, // register-register alu
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

	// funct3 of OP_IMM and OP
	typedef enum logic [FUNCT3_W-1:0] {
		ADD_SUB = 3'b000,
		SLL     = 3'b001,
		SLT     = 3'b010,
		SLTU    = 3'b011,
		XOR     = 3'b100,
		SR      = 3'b101, // srl or sra by bit 30
		OR      = 3'b110,
		AND     = 3'b111
	} alu_funct3_e;

	// funct3 of BRANCH, 010 and 011 are unused
	typedef enum logic [FUNCT3_W-1:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_funct3_e;

endpackage

/* rtl/exec_pkg.sv */
package exec_pkg;

	localparam int unsigned XLEN       = 32; // data path width
	localparam int unsigned REG_ADDR_W = 5;
	localparam int unsigned ILEN       = 32; // instruction width
	localparam int unsigned INST_STEP  = 4;  // fall-through pc increment
	localparam int unsigned SHAMT_W    = 5;

	// operations of the integer alu
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// how stage 2 forms write data and next pc
	typedef enum logic [1:0] {
		CTRL_ALU,    // write alu result, pc+4
		CTRL_BRANCH, // no write, conditional target
		CTRL_JAL,    // link, pc+imm
		CTRL_JALR    // link, rs1+imm
	} ctrl_e;

endpackage

/* rtl/int_alu.sv */
module int_alu (
	input  exec_pkg::alu_op_e            op_i,
	input  logic [exec_pkg::XLEN-1:0]    a_i,
	input  logic [exec_pkg::XLEN-1:0]    b_i,
	output logic [exec_pkg::XLEN-1:0]    result_o
);

	logic [exec_pkg::SHAMT_W-1:0] shamt;
	logic                         lt_s;
	logic                         lt_u;

	assign shamt = b_i[exec_pkg::SHAMT_W-1:0];
	assign lt_s  = $signed(a_i) < $signed(b_i);
	assign lt_u  = a_i < b_i;

	always_comb begin
		case (op_i)
			exec_pkg::ALU_ADD: begin
				result_o = a_i + b_i;
			end
			exec_pkg::ALU_SUB: begin
				result_o = a_i - b_i;
			end
			exec_pkg::ALU_SLL: begin
				result_o = a_i << shamt;
			end
			exec_pkg::ALU_SLT: begin
				result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_s};
			end
			exec_pkg::ALU_SLTU: begin
				result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_u};
			end
			exec_pkg::ALU_XOR: begin
				result_o = a_i ^ b_i;
			end
			exec_pkg::ALU_SRL: begin
				result_o = a_i >> shamt;
			end
			exec_pkg::ALU_SRA: begin
				result_o = $unsigned($signed(a_i) >>> shamt); // sign fills from the top
			end
			exec_pkg::ALU_OR: begin
				result_o = a_i | b_i;
			end
			exec_pkg::ALU_AND: begin
				result_o = a_i & b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

/* rtl/branch_unit.sv */
module branch_unit (
	input  exec_pkg::ctrl_e               ctrl_i,
	input  rv_isa_pkg::branch_funct3_e    cond_i,
	input  logic [exec_pkg::XLEN-1:0]     rs1_i,
	input  logic [exec_pkg::XLEN-1:0]     rs2_i,
	input  logic [exec_pkg::XLEN-1:0]     pc_i,
	input  logic [exec_pkg::XLEN-1:0]     imm_i,
	output logic                          redirect_o,
	output logic [exec_pkg::XLEN-1:0]     target_o
);

	logic                      eq;
	logic                      lt_s;
	logic                      lt_u;
	logic                      taken;
	logic [exec_pkg::XLEN-1:0] base;

	assign eq   = rs1_i == rs2_i;
	assign lt_s = $signed(rs1_i) < $signed(rs2_i);
	assign lt_u = rs1_i < rs2_i;

	always_comb begin
		case (cond_i)
			rv_isa_pkg::BEQ:  taken = eq;
			rv_isa_pkg::BNE:  taken = !eq;
			rv_isa_pkg::BLT:  taken = lt_s;
			rv_isa_pkg::BGE:  taken = !lt_s;
			rv_isa_pkg::BLTU: taken = lt_u;
			rv_isa_pkg::BGEU: taken = !lt_u;
			default:          taken = 1'b0;
		endcase
	end

	assign base     = (ctrl_i == exec_pkg::CTRL_JALR) ? rs1_i : pc_i; // jalr is register relative
	assign target_o = base + imm_i;

	assign redirect_o = (ctrl_i == exec_pkg::CTRL_JAL) ||
	                    (ctrl_i == exec_pkg::CTRL_JALR) ||
	                    (ctrl_i == exec_pkg::CTRL_BRANCH && taken);

endmodule

/* rtl/inst_decode.sv */
module inst_decode (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              valid_i,
	input  logic [exec_pkg::ILEN-1:0]         inst_i,
	input  logic [exec_pkg::XLEN-1:0]         pc_i,
	input  logic [exec_pkg::XLEN-1:0]         rs1_data_i,
	input  logic [exec_pkg::XLEN-1:0]         rs2_data_i,
	output logic                              dec_valid_o,
	output exec_pkg::ctrl_e                   dec_ctrl_o,
	output exec_pkg::alu_op_e                 dec_alu_op_o,
	output rv_isa_pkg::branch_funct3_e        dec_branch_cond_o,
	output logic [exec_pkg::XLEN-1:0]         dec_op_a_o,
	output logic [exec_pkg::XLEN-1:0]         dec_op_b_o,
	output logic [exec_pkg::XLEN-1:0]         dec_rs1_o,
	output logic [exec_pkg::XLEN-1:0]         dec_rs2_o,
	output logic [exec_pkg::XLEN-1:0]         dec_imm_o,
	output logic [exec_pkg::XLEN-1:0]         dec_pc_o,
	output logic [exec_pkg::REG_ADDR_W-1:0]   dec_rd_o,
	output logic                              dec_we_o,
	output logic                              dec_err_o
);

	rv_isa_pkg::opcode_e                opcode;
	logic [rv_isa_pkg::FUNCT3_W-1:0]    funct3;
	logic [rv_isa_pkg::FUNCT7_W-1:0]    funct7;
	logic [exec_pkg::REG_ADDR_W-1:0]    rd;
	logic                               alt;
	logic [exec_pkg::XLEN-1:0]          imm_i;
	logic [exec_pkg::XLEN-1:0]          imm_b;
	logic [exec_pkg::XLEN-1:0]          imm_u;
	logic [exec_pkg::XLEN-1:0]          imm_j;

	exec_pkg::ctrl_e                    ctrl;
	exec_pkg::alu_op_e                  alu_op;
	logic [exec_pkg::XLEN-1:0]          imm;
	logic [exec_pkg::XLEN-1:0]          op_a;
	logic [exec_pkg::XLEN-1:0]          op_b;
	logic                               legal;
	logic                               writes;

	// funct3 to alu op, shared by OP_IMM and OP
	function automatic exec_pkg::alu_op_e alu_map(
		input logic [rv_isa_pkg::FUNCT3_W-1:0] f3,
		input logic                            alt_bit,
		input logic                            sub_ok
	);
		exec_pkg::alu_op_e op;
		case (rv_isa_pkg::alu_funct3_e'(f3))
			rv_isa_pkg::ADD_SUB: op = (alt_bit && sub_ok) ? exec_pkg::ALU_SUB : exec_pkg::ALU_ADD;
			rv_isa_pkg::SLL:     op = exec_pkg::ALU_SLL;
			rv_isa_pkg::SLT:     op = exec_pkg::ALU_SLT;
			rv_isa_pkg::SLTU:    op = exec_pkg::ALU_SLTU;
			rv_isa_pkg::XOR:     op = exec_pkg::ALU_XOR;
			rv_isa_pkg::SR:      op = alt_bit ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
			rv_isa_pkg::OR:      op = exec_pkg::ALU_OR;
			default:             op = exec_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = rv_isa_pkg::opcode_e'(inst_i[rv_isa_pkg::OPCODE_W-1:0]);
	assign rd     = inst_i[rv_isa_pkg::RD_LSB +: exec_pkg::REG_ADDR_W];
	assign funct3 = inst_i[rv_isa_pkg::FUNCT3_LSB +: rv_isa_pkg::FUNCT3_W];
	assign funct7 = inst_i[rv_isa_pkg::FUNCT7_LSB +: rv_isa_pkg::FUNCT7_W];
	assign alt    = inst_i[rv_isa_pkg::ALT_BIT];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'h000};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		ctrl   = exec_pkg::CTRL_ALU;
		alu_op = exec_pkg::ALU_ADD;
		imm    = imm_i;
		op_a   = rs1_data_i;
		op_b   = rs2_data_i;
		legal  = 1'b1;
		writes = 1'b1;
		case (opcode)
			rv_isa_pkg::OP_IMM: begin
				op_b   = imm_i; // shifts only see the low bits
				alu_op = alu_map(funct3, alt, 1'b0);
			end
			rv_isa_pkg::OP: begin
				alu_op = alu_map(funct3, alt, 1'b1);
				if (funct7 != rv_isa_pkg::FUNCT7_BASE && funct7 != rv_isa_pkg::FUNCT7_ALT) begin
					legal = 1'b0; // M extension and others
				end
			end
			rv_isa_pkg::BRANCH: begin
				ctrl   = exec_pkg::CTRL_BRANCH;
				imm    = imm_b;
				writes = 1'b0;
				case (rv_isa_pkg::branch_funct3_e'(funct3))
					rv_isa_pkg::BEQ, rv_isa_pkg::BNE,
					rv_isa_pkg::BLT, rv_isa_pkg::BGE,
					rv_isa_pkg::BLTU, rv_isa_pkg::BGEU: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			rv_isa_pkg::JAL: begin
				ctrl = exec_pkg::CTRL_JAL;
				imm  = imm_j;
			end
			rv_isa_pkg::JALR: begin
				ctrl = exec_pkg::CTRL_JALR; // target bit 0 kept as is
			end
			rv_isa_pkg::LUI: begin
				imm  = imm_u;
				op_a = '0;
				op_b = imm_u;
			end
			rv_isa_pkg::AUIPC: begin
				imm  = imm_u;
				op_a = pc_i;
				op_b = imm_u;
			end
			default: begin
				legal  = 1'b0; // loads, stores, fence, system
				writes = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_o       <= 1'b0;
			dec_we_o          <= 1'b0;
			dec_err_o         <= 1'b0;
			dec_ctrl_o        <= exec_pkg::CTRL_ALU;
			dec_alu_op_o      <= exec_pkg::ALU_ADD;
			dec_branch_cond_o <= rv_isa_pkg::BEQ;
			dec_op_a_o        <= '0;
			dec_op_b_o        <= '0;
			dec_rs1_o         <= '0;
			dec_rs2_o         <= '0;
			dec_imm_o         <= '0;
			dec_pc_o          <= '0;
			dec_rd_o          <= '0;
		end else begin
			dec_valid_o       <= valid_i;
			dec_we_o          <= valid_i && legal && writes; // rd = 0 still writes
			dec_err_o         <= valid_i && !legal;
			dec_ctrl_o        <= ctrl;
			dec_alu_op_o      <= alu_op;
			dec_branch_cond_o <= rv_isa_pkg::branch_funct3_e'(funct3);
			dec_op_a_o        <= op_a;
			dec_op_b_o        <= op_b;
			dec_rs1_o         <= rs1_data_i;
			dec_rs2_o         <= rs2_data_i;
			dec_imm_o         <= imm;
			dec_pc_o          <= pc_i;
			dec_rd_o          <= rd;
		end
	end

endmodule

/* rtl/exec_stage.sv */
module exec_stage (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              dec_valid_i,
	input  exec_pkg::ctrl_e                   dec_ctrl_i,
	input  exec_pkg::alu_op_e                 dec_alu_op_i,
	input  rv_isa_pkg::branch_funct3_e        dec_branch_cond_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_op_a_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_op_b_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_rs1_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_rs2_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_imm_i,
	input  logic [exec_pkg::XLEN-1:0]         dec_pc_i,
	input  logic [exec_pkg::REG_ADDR_W-1:0]   dec_rd_i,
	input  logic                              dec_we_i,
	input  logic                              dec_err_i,
	output logic                              valid_o,
	output logic                              rd_we_o,
	output logic [exec_pkg::REG_ADDR_W-1:0]   rd_addr_o,
	output logic [exec_pkg::XLEN-1:0]         rd_wdata_o,
	output logic [exec_pkg::XLEN-1:0]         pc_next_o,
	output logic                              inst_err_o
);

	logic [exec_pkg::XLEN-1:0] alu_result;
	logic [exec_pkg::XLEN-1:0] target;
	logic                      redirect;
	logic [exec_pkg::XLEN-1:0] pc_seq;
	logic                      is_jump;
	logic [exec_pkg::XLEN-1:0] wdata;
	logic [exec_pkg::XLEN-1:0] pc_next;

	int_alu alu_i (
		.op_i     (dec_alu_op_i),
		.a_i      (dec_op_a_i),
		.b_i      (dec_op_b_i),
		.result_o (alu_result)
	);

	branch_unit bru_i (
		.ctrl_i     (dec_ctrl_i),
		.cond_i     (dec_branch_cond_i),
		.rs1_i      (dec_rs1_i),
		.rs2_i      (dec_rs2_i),
		.pc_i       (dec_pc_i),
		.imm_i      (dec_imm_i),
		.redirect_o (redirect),
		.target_o   (target)
	);

	assign pc_seq  = dec_pc_i + exec_pkg::XLEN'(exec_pkg::INST_STEP); // also the link address
	assign is_jump = (dec_ctrl_i == exec_pkg::CTRL_JAL) || (dec_ctrl_i == exec_pkg::CTRL_JALR);

	assign wdata   = dec_err_i ? '0 : (is_jump ? pc_seq : alu_result);
	assign pc_next = dec_err_i ? '0 : (redirect ? target : pc_seq); // illegal gives pc 0

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o    <= 1'b0;
			rd_we_o    <= 1'b0;
			inst_err_o <= 1'b0;
			rd_addr_o  <= '0;
			rd_wdata_o <= '0;
			pc_next_o  <= '0;
		end else begin
			valid_o    <= dec_valid_i;
			rd_we_o    <= dec_we_i; // already qualified in decode
			inst_err_o <= dec_err_i;
			rd_addr_o  <= dec_rd_i;
			rd_wdata_o <= wdata;
			pc_next_o  <= pc_next;
		end
	end

endmodule

/* rtl/rv_exec_top.sv */
module rv_exec_top (
	input  logic                              clk_i,
	input  logic                              rst_n_i,
	input  logic                              valid_i,
	input  logic [exec_pkg::ILEN-1:0]         inst_i,
	input  logic [exec_pkg::XLEN-1:0]         pc_i,
	input  logic [exec_pkg::XLEN-1:0]         rs1_data_i,
	input  logic [exec_pkg::XLEN-1:0]         rs2_data_i,
	output logic                              valid_o,
	output logic                              rd_we_o,
	output logic [exec_pkg::REG_ADDR_W-1:0]   rd_addr_o,
	output logic [exec_pkg::XLEN-1:0]         rd_wdata_o,
	output logic [exec_pkg::XLEN-1:0]         pc_next_o,
	output logic                              inst_err_o
);

	// decode to execute, all registered in stage 1
	logic                              dec_valid;
	exec_pkg::ctrl_e                   dec_ctrl;
	exec_pkg::alu_op_e                 dec_alu_op;
	rv_isa_pkg::branch_funct3_e        dec_branch_cond;
	logic [exec_pkg::XLEN-1:0]         dec_op_a;
	logic [exec_pkg::XLEN-1:0]         dec_op_b;
	logic [exec_pkg::XLEN-1:0]         dec_rs1;
	logic [exec_pkg::XLEN-1:0]         dec_rs2;
	logic [exec_pkg::XLEN-1:0]         dec_imm;
	logic [exec_pkg::XLEN-1:0]         dec_pc;
	logic [exec_pkg::REG_ADDR_W-1:0]   dec_rd;
	logic                              dec_we;
	logic                              dec_err;

	inst_decode decode_i (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.valid_i           (valid_i),
		.inst_i            (inst_i),
		.pc_i              (pc_i),
		.rs1_data_i        (rs1_data_i),
		.rs2_data_i        (rs2_data_i),
		.dec_valid_o       (dec_valid),
		.dec_ctrl_o        (dec_ctrl),
		.dec_alu_op_o      (dec_alu_op),
		.dec_branch_cond_o (dec_branch_cond),
		.dec_op_a_o        (dec_op_a),
		.dec_op_b_o        (dec_op_b),
		.dec_rs1_o         (dec_rs1),
		.dec_rs2_o         (dec_rs2),
		.dec_imm_o         (dec_imm),
		.dec_pc_o          (dec_pc),
		.dec_rd_o          (dec_rd),
		.dec_we_o          (dec_we),
		.dec_err_o         (dec_err)
	);

	exec_stage exec_i (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.dec_valid_i       (dec_valid),
		.dec_ctrl_i        (dec_ctrl),
		.dec_alu_op_i      (dec_alu_op),
		.dec_branch_cond_i (dec_branch_cond),
		.dec_op_a_i        (dec_op_a),
		.dec_op_b_i        (dec_op_b),
		.dec_rs1_i         (dec_rs1),
		.dec_rs2_i         (dec_rs2),
		.dec_imm_i         (dec_imm),
		.dec_pc_i          (dec_pc),
		.dec_rd_i          (dec_rd),
		.dec_we_i          (dec_we),
		.dec_err_i         (dec_err),
		.valid_o           (valid_o),
		.rd_we_o           (rd_we_o),
		.rd_addr_o         (rd_addr_o),
		.rd_wdata_o        (rd_wdata_o),
		.pc_next_o         (pc_next_o),
		.inst_err_o        (inst_err_o)
	);

endmodule

/* bench/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// arguments in order are inst pc rs1 rs2 we wdata pc_next err
// rd is taken from inst[11:7]
task automatic fill_table();
	add_vec(imm_op(rv_isa_pkg::ADD_SUB, 12'h005), 'h100, 10, 0, 1, 15, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::ADD_SUB, 12'hfff), 'h100, 10, 0, 1, 9, 'h104, 0); // negative imm
	add_vec(imm_op(rv_isa_pkg::ADD_SUB, 12'h003) & ~'hf80, 'h104, 4, 0, 1, 7, 'h108, 0); // rd 0
	add_vec(imm_op(rv_isa_pkg::SLT, 12'hfff), 'h100, 5, 0, 1, 0, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::SLTU, 12'hfff), 'h100, 'h1000, 0, 1, 1, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::XOR, 12'h0ff), 'h100, 'h0f0, 0, 1, 'h00f, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::OR, 12'h800), 'h100, 1, 0, 1, 'hfffff801, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::AND, 12'h0f0), 'h100, 'h12345678, 0, 1, 'h70, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::SLL, 12'h004), 'h100, 1, 0, 1, 'h10, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::SR, 12'h004), 'h100, 'h80000000, 0, 1, 'h08000000, 'h104, 0);
	add_vec(imm_op(rv_isa_pkg::SR, 12'h404), 'h100, 'h80000000, 0, 1, 'hf8000000, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::ADD_SUB, 0), 'h100, 7, 8, 1, 15, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::ADD_SUB, 1), 'h100, 5, 7, 1, 'hfffffffe, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::SLL, 0), 'h100, 1, 'h21, 1, 2, 'h104, 0); // only low 5 bits
	add_vec(r_op(rv_isa_pkg::SLT, 0), 'h100, 'hffffffff, 1, 1, 1, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::SLTU, 0), 'h100, 'hffffffff, 1, 1, 0, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::XOR, 0), 'h100, 'hff00ff00, 'h0ff00ff0, 1, 'hf0f0f0f0, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::SR, 0), 'h100, 'hf0000000, 8, 1, 'h00f00000, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::SR, 1), 'h100, 'hf0000000, 8, 1, 'hfff00000, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::OR, 0), 'h100, 'h0f, 'hf0, 1, 'hff, 'h104, 0);
	add_vec(r_op(rv_isa_pkg::AND, 0), 'h100, 'hff00, 'h0ff0, 1, 'h0f00, 'h104, 0);
	add_bubble();
	add_vec(br(rv_isa_pkg::BEQ, 13'h010), 'h200, 5, 5, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BEQ, 13'h010), 'h200, 5, 6, 0, 0, 'h204, 0);
	add_vec(br(rv_isa_pkg::BEQ, 13'h1ff8), 'h200, 5, 5, 0, 0, 'h1f8, 0); // backward
	add_vec(br(rv_isa_pkg::BNE, 13'h010), 'h200, 5, 6, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BNE, 13'h010), 'h200, 5, 5, 0, 0, 'h204, 0);
	add_vec(br(rv_isa_pkg::BLT, 13'h010), 'h200, 'hffffffff, 1, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BLT, 13'h010), 'h200, 1, 'hffffffff, 0, 0, 'h204, 0);
	add_vec(br(rv_isa_pkg::BGE, 13'h010), 'h200, 1, 'hffffffff, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BGE, 13'h010), 'h200, 'hffffffff, 1, 0, 0, 'h204, 0);
	add_vec(br(rv_isa_pkg::BLTU, 13'h010), 'h200, 1, 'hffffffff, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BLTU, 13'h010), 'h200, 'hffffffff, 1, 0, 0, 'h204, 0);
	add_vec(br(rv_isa_pkg::BGEU, 13'h010), 'h200, 'hffffffff, 1, 0, 0, 'h210, 0);
	add_vec(br(rv_isa_pkg::BGEU, 13'h010), 'h200, 1, 'hffffffff, 0, 0, 'h204, 0);
	add_vec(jal(21'h000100), 'h300, 0, 0, 1, 'h304, 'h400, 0);
	add_vec(jal(21'h1ffffc), 'h300, 0, 0, 1, 'h304, 'h2fc, 0);
	add_vec(i_type(rv_isa_pkg::JALR, 3'b000, 12'h008), 'h300, 'h1001, 0, 1, 'h304, 'h1009, 0);
	add_vec(u_type(rv_isa_pkg::LUI, 20'h12345), 'h300, 0, 0, 1, 'h12345000, 'h304, 0);
	add_vec(u_type(rv_isa_pkg::AUIPC, 20'h00001), 'h300, 0, 0, 1, 'h1300, 'h304, 0);
	add_vec(i_type(7'b0000011, 3'b010, 12'h000), 'h400, 1, 2, 0, 0, 0, 1); // load
	add_vec(i_type(7'b0100011, 3'b010, 12'h000), 'h400, 1, 2, 0, 0, 0, 1); // store
	add_vec(i_type(7'b1110011, 3'b001, 12'h300), 'h400, 1, 2, 0, 0, 0, 1); // csrrw
	add_vec(r_op(rv_isa_pkg::ADD_SUB, 0) | 'h02000000, 'h400, 3, 4, 0, 0, 0, 1); // mul
	add_vec('hffffffff, 'h400, 1, 2, 0, 0, 0, 1);
endtask

`endif

/* bench/tb_rv_exec.sv */
module tb_rv_exec;

	localparam int PERIOD     = 40;
	localparam int RAND_COUNT = 20;

	logic        clk;
	logic        rst_n;
	logic        valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic        valid_o;
	logic        rd_we_o;
	logic [4:0]  rd_addr_o;
	logic [31:0] rd_wdata_o;
	logic [31:0] pc_next_o;
	logic        inst_err_o;

	// one entry per queue slot
	logic [31:0] v_valid[$];
	logic [31:0] v_inst[$];
	logic [31:0] v_pc[$];
	logic [31:0] v_rs1[$];
	logic [31:0] v_rs2[$];
	logic [31:0] v_we[$];
	logic [31:0] v_wdata[$];
	logic [31:0] v_pcn[$];
	logic [31:0] v_err[$];

	integer seed;
	bit     table_ready;

	rv_exec_top dut_i (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.valid_i    (valid),
		.inst_i     (inst),
		.pc_i       (pc),
		.rs1_data_i (rs1),
		.rs2_data_i (rs2),
		.valid_o    (valid_o),
		.rd_we_o    (rd_we_o),
		.rd_addr_o  (rd_addr_o),
		.rd_wdata_o (rd_wdata_o),
		.pc_next_o  (pc_next_o),
		.inst_err_o (inst_err_o)
	);

	function automatic logic [31:0] i_type(logic [6:0] op, logic [2:0] f3, logic [11:0] imm);
		return {imm, 5'd1, f3, 5'd1, op}; // rd x1, rs1 x1
	endfunction

	function automatic logic [31:0] imm_op(logic [2:0] f3, logic [11:0] imm);
		return i_type(rv_isa_pkg::OP_IMM, f3, imm);
	endfunction

	function automatic logic [31:0] r_op(logic [2:0] f3, logic alt);
		logic [6:0] f7;
		f7 = alt ? rv_isa_pkg::FUNCT7_ALT : rv_isa_pkg::FUNCT7_BASE;
		return {f7, 5'd2, 5'd1, f3, 5'd1, rv_isa_pkg::OP};
	endfunction

	function automatic logic [31:0] br(logic [2:0] f3, logic [12:0] imm);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
	endfunction

	function automatic logic [31:0] u_type(logic [6:0] op, logic [19:0] imm);
		return {imm, 5'd1, op};
	endfunction

	function automatic logic [31:0] jal(logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, rv_isa_pkg::JAL};
	endfunction

	task automatic add_vec(logic [31:0] i, logic [31:0] p, logic [31:0] a, logic [31:0] b,
			logic [31:0] we, logic [31:0] wd, logic [31:0] pcn, logic [31:0] err);
		v_valid.push_back(1);
		v_inst.push_back(i);
		v_pc.push_back(p);
		v_rs1.push_back(a);
		v_rs2.push_back(b);
		v_we.push_back(we);
		v_wdata.push_back(wd);
		v_pcn.push_back(pcn);
		v_err.push_back(err);
	endtask

	task automatic add_bubble();
		add_vec(r_op(rv_isa_pkg::ADD_SUB, 0), 'h100, 1, 1, 0, 0, 0, 0);
		v_valid[v_valid.size()-1] = 0;
	endtask

	`include "tb_vectors.svh"

	// reference model for the random R-type pass
	task automatic add_random();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ins;
		logic [31:0] exp;
		for (int k = 0; k < RAND_COUNT; k++) begin
			a = $random(seed);
			b = $random(seed);
			case (k % 5)
				0: begin
					ins = r_op(rv_isa_pkg::ADD_SUB, 0);
					exp = a + b;
				end
				1: begin
					ins = r_op(rv_isa_pkg::ADD_SUB, 1);
					exp = a - b;
				end
				2: begin
					ins = r_op(rv_isa_pkg::XOR, 0);
					exp = a ^ b;
				end
				3: begin
					ins = r_op(rv_isa_pkg::SLT, 0);
					exp = ($signed(a) < $signed(b)) ? 1 : 0;
				end
				default: begin
					ins = r_op(rv_isa_pkg::SLTU, 0);
					exp = (a < b) ? 1 : 0;
				end
			endcase
			add_vec(ins, 'h500 + 4 * k, a, b, 1, exp, 'h504 + 4 * k, 0);
		end
	endtask

	task automatic check_val(logic [31:0] got, logic [31:0] exp, string what);
		if (got !== exp) begin
			$display("FAIL time %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic check_idle(string when);
		check_val(32'(valid_o), 0, {"valid_o ", when});
		check_val(32'(rd_we_o), 0, {"rd_we_o ", when});
		check_val(32'(inst_err_o), 0, {"inst_err_o ", when});
	endtask

	task automatic check_entry(int i);
		logic [31:0] ins;
		ins = v_inst[i];
		check_val(32'(valid_o), v_valid[i], $sformatf("entry %0d valid_o", i));
		check_val(32'(rd_we_o), v_we[i], $sformatf("entry %0d rd_we_o", i));
		check_val(32'(inst_err_o), v_err[i], $sformatf("entry %0d inst_err_o", i));
		if (v_valid[i]) begin
			check_val(pc_next_o, v_pcn[i], $sformatf("entry %0d pc_next_o", i));
		end
		if (v_we[i]) begin
			check_val(32'(rd_addr_o), 32'(ins[11:7]), $sformatf("entry %0d rd_addr_o", i));
		end
		if (v_we[i] || v_err[i]) begin
			check_val(rd_wdata_o, v_wdata[i], $sformatf("entry %0d rd_wdata_o", i));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		wait (table_ready);
		#((v_inst.size() + 10) * PERIOD);
		$display("TEST FAILED");
		$fatal(1, "simulation timed out before all entries were checked");
	end

	initial begin
		valid = 1'b0;
		inst  = '0;
		pc    = '0;
		rs1   = '0;
		rs2   = '0;
		rst_n = 1'b0;
		seed  = 32'hd3d1;
		fill_table();
		add_random();
		table_ready = 1'b1;
		@(negedge clk);
		check_idle("in reset");
		@(negedge clk);
		rst_n = 1'b1;
		for (int n = 0; n < v_inst.size() + 2; n++) begin
			if (n >= 2) begin
				check_entry(n - 2); // two instructions in flight
			end else begin
				check_idle("after reset");
			end
			if (n < v_inst.size()) begin
				valid = v_valid[n][0];
				inst  = v_inst[n];
				pc    = v_pc[n];
				rs1   = v_rs1[n];
				rs2   = v_rs2[n];
			end else begin
				valid = 1'b0;
			end
			@(negedge clk);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+bench
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/inst_decode.sv
rtl/exec_stage.sv
rtl/rv_exec_top.sv
bench/tb_rv_exec.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_exec
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
